// File: tb.f
+incdir+include
hdl/afifo_pkg.sv
hdl/afifo_dpram.sv
hdl/afifo_wr_ctrl.sv
hdl/afifo_rd_ctrl.sv
hdl/afifo_top.sv
test/afifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the afifo testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module afifo_tb -Mdir "$OBJ" -f tb.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

"./$OBJ/Vafifo_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Regression failed" "$LOG"; then
  echo "simulation reported errors, see $LOG"
  exit 1
fi

echo "simulation finished without errors"
exit 0

// File: test/afifo_tb.sv
`include "afifo_defs.svh"

module afifo_tb import afifo_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH         = `AFIFO_DEPTH;
  localparam int AFULL         = `AFIFO_AFULL_DEF;
  localparam int RST_CYCLES    = 8;
  localparam int SETTLE_CYCLES = 6;    // reset release in both domains
  localparam int FILL_CYCLES   = 30;
  localparam int DRAIN_CYCLES  = 30;   // rd_clk cycles
  localparam int MIX_CYCLES    = 680;  // per half
  // drain phases counted twice for the slower rd_clk
  localparam int PHASE_CYCLES  = RST_CYCLES + SETTLE_CYCLES + FILL_CYCLES
                                 + 2 * MIX_CYCLES + 4 * DRAIN_CYCLES;
  localparam int MAX_CYCLES    = 2 * PHASE_CYCLES;
  localparam logic [31:0] SEED = 32'h9a7e_bcfb;

  logic            wr_clk;
  logic            rd_clk;
  logic            rd_rst_n;
  afifo_push_s     push;
  logic            pop;
  afifo_data_t     rd_data;
  afifo_wr_flags_s wr_flags;
  afifo_rd_flags_s rd_flags;

  afifo_data_t model_q[$];
  int          model_cnt;
  int          errors;
  int          data_checks;
  int          push_total;
  int          pop_total;
  int          cycles;
  int          wr_rate;       // push chance in percent
  int          rd_rate;       // pop chance in percent
  bit          push_go;       // push taken at next wr_clk edge
  bit          pop_go;        // pop taken at next rd_clk edge
  bit          checks_on;
  afifo_data_t last_data;

  initial wr_clk = 1'b0;
  always #20 wr_clk = ~wr_clk;

  initial rd_clk = 1'b0;
  always #28 rd_clk = ~rd_clk;

  afifo_top i_dut (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .push     (push),
    .pop      (pop),
    .rd_data  (rd_data),
    .wr_flags (wr_flags),
    .rd_flags (rd_flags)
  );

  // ----------------------------------------------------------------------
  // reporting
  // ----------------------------------------------------------------------

  task automatic log_mismatch(input string name, input int exp, input int act);
    errors++;
    $display("** Error [%s]: expected %0d (0x%0h), actual %0d (0x%0h)",
             name, exp, exp, act, act);
  endtask

  task automatic expect_value(input string name, input int exp, input int act);
    value_ok: assert (exp == act) else begin
      log_mismatch(name, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("pushes %0d, pops %0d, data checks %0d, errors %0d",
             push_total, pop_total, data_checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  // ----------------------------------------------------------------------
  // writer and reader driven 2 ns after their own edge
  // ----------------------------------------------------------------------

  always @(posedge wr_clk) begin
    #2;
    if (push_go) begin
      model_q.push_back(push.data);
      model_cnt++;
      push_total++;
    end
    // a refused word stays on the bus until taken
    if (push_go || !push.en || wr_rate == 0) begin
      push.en   = (int'($urandom_range(99)) < wr_rate);
      push.data = afifo_data_t'($urandom);
    end
    push_go = push.en && !wr_flags.full;  // full is stable until next edge
  end

  task automatic check_pop();
    afifo_data_t exp;
    if (model_cnt == 0) begin
      errors++;
      $display("** Error: a pop was taken while the model queue was empty");
    end else begin
      exp = model_q.pop_front();
      model_cnt--;
      pop_total++;
      data_checks++;
      last_data = exp;
      expect_value("data_integrity", int'(exp), int'(rd_data));
    end
  endtask

  always @(posedge rd_clk) begin
    #2;
    if (pop_go) begin
      check_pop();
    end
    pop    = (int'($urandom_range(99)) < rd_rate);
    pop_go = pop && !rd_flags.empty;
  end

  // ----------------------------------------------------------------------
  // flag checks at the falling edge where the flags are stable
  // ----------------------------------------------------------------------

  full_at_depth: assert property (@(negedge wr_clk) disable iff (!checks_on)
      model_cnt != DEPTH || wr_flags.full)
    else log_mismatch("full_at_depth", 1, int'(wr_flags.full));

  afull_at_depth: assert property (@(negedge wr_clk) disable iff (!checks_on)
      model_cnt != DEPTH || wr_flags.afull)
    else log_mismatch("afull_at_depth", 1, int'(wr_flags.afull));

  // read pointer lags by a few pops at most
  afull_low: assert property (@(negedge wr_clk) disable iff (!checks_on)
      model_cnt >= AFULL - 3 || !wr_flags.afull)
    else log_mismatch("afull_low", 0, int'(wr_flags.afull));

  empty_at_zero: assert property (@(negedge rd_clk) disable iff (!checks_on)
      model_cnt != 0 || rd_flags.empty)
    else log_mismatch("empty_at_zero", 1, int'(rd_flags.empty));

  aempty_at_zero: assert property (@(negedge rd_clk) disable iff (!checks_on)
      model_cnt != 0 || rd_flags.aempty)
    else log_mismatch("aempty_at_zero", 1, int'(rd_flags.aempty));

  // ----------------------------------------------------------------------
  // timeout
  // ----------------------------------------------------------------------

  always @(posedge wr_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      errors++;
      $display("Timeout: the run did not finish within %0d wr_clk cycles", MAX_CYCLES);
      finish_run();
    end
  end

  // ----------------------------------------------------------------------
  // phases
  // ----------------------------------------------------------------------

  task automatic check_reset_state();
    expect_value("reset_full", 0, int'(wr_flags.full));
    expect_value("reset_afull", 0, int'(wr_flags.afull));
    expect_value("reset_empty", 1, int'(rd_flags.empty));
    expect_value("reset_aempty", 1, int'(rd_flags.aempty));
    expect_value("reset_rd_data", 0, int'(rd_data));
  endtask

  task automatic wait_empty_rise();
    int n;
    n = 0;
    while (!rd_flags.empty && n < 4) begin
      @(posedge rd_clk);
      #3;
      n++;
    end
    expect_value("empty_after_drain", 1, int'(rd_flags.empty));
  endtask

  initial begin
    int mark;
    void'($urandom(SEED));
    rd_rst_n    = 1'b0;
    push        = '0;
    pop         = 1'b0;
    push_go     = 1'b0;
    pop_go      = 1'b0;
    checks_on   = 1'b0;
    last_data   = '0;
    model_cnt   = 0;
    errors      = 0;
    data_checks = 0;
    push_total  = 0;
    pop_total   = 0;
    cycles      = 0;
    wr_rate     = 0;
    rd_rate     = 0;

    repeat (RST_CYCLES) @(posedge wr_clk);
    #2;
    rd_rst_n = 1'b1;
    #1;
    check_reset_state();
    checks_on = 1'b1;
    repeat (SETTLE_CYCLES) @(posedge wr_clk);

    // fill with the reader idle
    mark    = push_total;
    wr_rate = 100;
    repeat (FILL_CYCLES) @(posedge wr_clk);
    wr_rate = 0;
    repeat (2) @(posedge wr_clk);
    #5;
    expect_value("fill_count", DEPTH, push_total - mark);
    expect_value("fill_full", 1, int'(wr_flags.full));

    // drain with the writer idle
    mark    = pop_total;
    rd_rate = 100;
    repeat (DRAIN_CYCLES) @(posedge rd_clk);
    rd_rate = 0;
    repeat (2) @(posedge rd_clk);
    #5;
    expect_value("drain_count", DEPTH, pop_total - mark);

    // writer ahead then reader ahead
    wr_rate = 80;
    rd_rate = 50;
    repeat (MIX_CYCLES) @(posedge wr_clk);
    wr_rate = 40;
    rd_rate = 80;
    repeat (MIX_CYCLES) @(posedge wr_clk);

    // final drain
    wr_rate = 0;
    rd_rate = 100;
    @(posedge wr_clk);  // last accepted push reaches the model
    while (model_cnt != 0) begin
      @(posedge rd_clk);
    end
    wait_empty_rise();

    // pops while empty leave the output alone
    mark = pop_total;
    repeat (6) @(posedge rd_clk);
    #5;
    expect_value("pop_while_empty", int'(last_data), int'(rd_data));
    expect_value("pops_while_empty", mark, pop_total);
    rd_rate = 0;
    repeat (2) @(posedge rd_clk);

    finish_run();
  end

endmodule

// File: hdl/afifo_top.sv
`include "afifo_defs.svh"

module afifo_top import afifo_pkg::*; #(
  parameter afifo_level_t AFULL  = `AFIFO_AFULL_DEF,
  parameter afifo_level_t AEMPTY = `AFIFO_AEMPTY_DEF
) (
  input  logic            wr_clk,
  input  logic            rd_clk,
  input  logic            rd_rst_n,
  input  afifo_push_s     push,
  input  logic            pop,
  output afifo_data_t     rd_data,
  output afifo_wr_flags_s wr_flags,
  output afifo_rd_flags_s rd_flags
);

  afifo_ptr_t  wr_gray;        // wr_clk domain
  afifo_ptr_t  rd_gray;        // rd_clk domain
  logic        ram_wr_en;
  afifo_addr_t ram_wr_addr;
  afifo_data_t ram_wr_data;
  logic        ram_rd_en;
  afifo_addr_t ram_rd_addr;
  logic        rd_rst_sync_n;

  // ----------------------------------------------------------------------
  // write domain
  // ----------------------------------------------------------------------

  afifo_wr_ctrl #(
    .AFULL (AFULL)
  ) u_wr_ctrl (
    .wr_clk      (wr_clk),
    .rd_rst_n    (rd_rst_n),
    .push        (push),
    .rd_gray     (rd_gray),
    .wr_gray     (wr_gray),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .ram_wr_data (ram_wr_data),
    .wr_flags    (wr_flags)
  );

  // ----------------------------------------------------------------------
  // read domain
  // ----------------------------------------------------------------------

  afifo_rd_ctrl #(
    .AEMPTY (AEMPTY)
  ) u_rd_ctrl (
    .rd_clk        (rd_clk),
    .rd_rst_n      (rd_rst_n),
    .pop           (pop),
    .wr_gray       (wr_gray),
    .rd_gray       (rd_gray),
    .ram_rd_en     (ram_rd_en),
    .ram_rd_addr   (ram_rd_addr),
    .rd_rst_sync_n (rd_rst_sync_n),
    .rd_flags      (rd_flags)
  );

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------

  afifo_dpram u_dpram (
    .wr_clk   (wr_clk),
    .wr_en    (ram_wr_en),
    .wr_addr  (ram_wr_addr),
    .wr_data  (ram_wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_sync_n),  // released in rd_clk
    .rd_en    (ram_rd_en),
    .rd_addr  (ram_rd_addr),
    .rd_data  (rd_data)
  );

endmodule

// File: hdl/afifo_rd_ctrl.sv
`include "afifo_defs.svh"

module afifo_rd_ctrl import afifo_pkg::*; #(
  parameter afifo_level_t AEMPTY = `AFIFO_AEMPTY_DEF
) (
  input  logic            rd_clk,
  input  logic            rd_rst_n,
  input  logic            pop,
  input  afifo_ptr_t      wr_gray,
  output afifo_ptr_t      rd_gray,
  output logic            ram_rd_en,
  output afifo_addr_t     ram_rd_addr,
  output logic            rd_rst_sync_n,
  output afifo_rd_flags_s rd_flags
);

  localparam int PTR_MSB = `AFIFO_ADDR_WIDTH;

  logic         rst_meta;
  logic         pop_ok;
  afifo_ptr_t   rd_bin;
  afifo_ptr_t   rd_bin_nxt;
  afifo_ptr_t   rd_gray_nxt;
  afifo_ptr_t   wr_gray_s1;
  afifo_ptr_t   wr_gray_s2;
  afifo_ptr_t   wr_bin_sync;
  afifo_level_t used_nxt;

  // ----------------------------------------------------------------------
  // reset release into rd_clk
  // ----------------------------------------------------------------------

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rst_meta      <= 1'b0;
      rd_rst_sync_n <= 1'b0;
    end else begin
      rst_meta      <= 1'b1;
      rd_rst_sync_n <= rst_meta;  // also resets ram read reg
    end
  end

  // ----------------------------------------------------------------------
  // read pointer
  // ----------------------------------------------------------------------

  assign pop_ok      = pop & ~rd_flags.empty;
  assign rd_bin_nxt  = rd_bin + afifo_ptr_t'(pop_ok);
  assign rd_gray_nxt = afifo_bin2gray(rd_bin_nxt);

  always_ff @(posedge rd_clk or negedge rd_rst_sync_n) begin
    if (!rd_rst_sync_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // ----------------------------------------------------------------------
  // write pointer synchronizer
  // ----------------------------------------------------------------------

  always_ff @(posedge rd_clk or negedge rd_rst_sync_n) begin
    if (!rd_rst_sync_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;  // stable gray value
    end
  end

  assign wr_bin_sync = afifo_gray2bin(wr_gray_s2);

  // words left after this cycle's pop
  assign used_nxt = wr_bin_sync - rd_bin_nxt;

  // ----------------------------------------------------------------------
  // flags
  // ----------------------------------------------------------------------

  // both flags come up set with nothing stored
  always_ff @(posedge rd_clk or negedge rd_rst_sync_n) begin
    if (!rd_rst_sync_n) begin
      rd_flags.empty  <= 1'b1;
      rd_flags.aempty <= 1'b1;
    end else begin
      rd_flags.empty  <= (rd_gray_nxt == wr_gray_s2);
      rd_flags.aempty <= (used_nxt <= AEMPTY);
    end
  end

  // ram read side
  assign ram_rd_en   = pop_ok;
  assign ram_rd_addr = rd_bin[PTR_MSB-1:0];

endmodule

// File: hdl/afifo_wr_ctrl.sv
`include "afifo_defs.svh"

module afifo_wr_ctrl import afifo_pkg::*; #(
  parameter afifo_level_t AFULL = `AFIFO_AFULL_DEF
) (
  input  logic            wr_clk,
  input  logic            rd_rst_n,
  input  afifo_push_s     push,
  input  afifo_ptr_t      rd_gray,
  output afifo_ptr_t      wr_gray,
  output logic            ram_wr_en,
  output afifo_addr_t     ram_wr_addr,
  output afifo_data_t     ram_wr_data,
  output afifo_wr_flags_s wr_flags
);

  localparam int PTR_MSB = `AFIFO_ADDR_WIDTH;

  logic         rst_meta;
  logic         wr_rst_sync_n;
  logic         push_ok;
  afifo_ptr_t   wr_bin;
  afifo_ptr_t   wr_bin_nxt;
  afifo_ptr_t   wr_gray_nxt;
  afifo_ptr_t   rd_gray_s1;
  afifo_ptr_t   rd_gray_s2;
  afifo_ptr_t   rd_bin_sync;
  afifo_ptr_t   full_match;
  afifo_level_t used_nxt;

  // ----------------------------------------------------------------------
  // reset release into wr_clk
  // ----------------------------------------------------------------------

  always_ff @(posedge wr_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rst_meta      <= 1'b0;
      wr_rst_sync_n <= 1'b0;
    end else begin
      rst_meta      <= 1'b1;
      wr_rst_sync_n <= rst_meta;  // second stage
    end
  end

  // ----------------------------------------------------------------------
  // write pointer
  // ----------------------------------------------------------------------

  assign push_ok     = push.en & ~wr_flags.full;
  assign wr_bin_nxt  = wr_bin + afifo_ptr_t'(push_ok);
  assign wr_gray_nxt = afifo_bin2gray(wr_bin_nxt);

  always_ff @(posedge wr_clk or negedge wr_rst_sync_n) begin
    if (!wr_rst_sync_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;  // registered before it crosses
    end
  end

  // ----------------------------------------------------------------------
  // read pointer synchronizer
  // ----------------------------------------------------------------------

  always_ff @(posedge wr_clk or negedge wr_rst_sync_n) begin
    if (!wr_rst_sync_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  assign rd_bin_sync = afifo_gray2bin(rd_gray_s2);

  // write one lap ahead shows as the top two gray bits flipped
  assign full_match = {~rd_gray_s2[PTR_MSB:PTR_MSB-1], rd_gray_s2[PTR_MSB-2:0]};
  assign used_nxt   = wr_bin_nxt - rd_bin_sync;  // modulo wrap

  // ----------------------------------------------------------------------
  // flags
  // ----------------------------------------------------------------------

  always_ff @(posedge wr_clk or negedge wr_rst_sync_n) begin
    if (!wr_rst_sync_n) begin
      wr_flags <= '0;
    end else begin
      wr_flags.full  <= (wr_gray_nxt == full_match);
      wr_flags.afull <= (used_nxt >= AFULL);
    end
  end

  // ram write side
  assign ram_wr_en   = push_ok;
  assign ram_wr_addr = wr_bin[PTR_MSB-1:0];  // drop wrap bit
  assign ram_wr_data = push.data;

endmodule

// File: hdl/afifo_dpram.sv
`include "afifo_defs.svh"

module afifo_dpram import afifo_pkg::*; (
  input  logic        wr_clk,
  input  logic        wr_en,
  input  afifo_addr_t wr_addr,
  input  afifo_data_t wr_data,
  input  logic        rd_clk,
  input  logic        rd_rst_n,
  input  logic        rd_en,
  input  afifo_addr_t rd_addr,
  output afifo_data_t rd_data
);

  afifo_data_t mem [`AFIFO_DEPTH];

  // ----------------------------------------------------------------------
  // write port, wr_clk domain
  // ----------------------------------------------------------------------

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ----------------------------------------------------------------------
  // registered read port, rd_clk domain
  // ----------------------------------------------------------------------

  // word is held until the next enabled read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];  // popped word visible at this edge
    end
  end

endmodule

// File: hdl/afifo_pkg.sv
`include "afifo_defs.svh"

package afifo_pkg;

  typedef logic [`AFIFO_DATA_WIDTH-1:0] afifo_data_t;
  typedef logic [`AFIFO_ADDR_WIDTH-1:0] afifo_addr_t;
  typedef logic [`AFIFO_ADDR_WIDTH:0]   afifo_ptr_t;    // address plus wrap bit
  typedef logic [`AFIFO_ADDR_WIDTH:0]   afifo_level_t;  // 0 up to depth

  typedef struct packed {
    logic        en;
    afifo_data_t data;
  } afifo_push_s;

  typedef struct packed {
    logic full;
    logic afull;
  } afifo_wr_flags_s;

  typedef struct packed {
    logic empty;
    logic aempty;
  } afifo_rd_flags_s;

  function automatic afifo_ptr_t afifo_bin2gray(input afifo_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic afifo_ptr_t afifo_gray2bin(input afifo_ptr_t gray);
    afifo_ptr_t bin;
    bin[`AFIFO_ADDR_WIDTH] = gray[`AFIFO_ADDR_WIDTH];
    for (int i = `AFIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];  // xor down from msb
    end
    return bin;
  endfunction

endpackage

// File: include/afifo_defs.svh
`ifndef AFIFO_DEFS_SVH
`define AFIFO_DEFS_SVH

// ----------------------------------------------------------------------
// storage geometry
// ----------------------------------------------------------------------

`define AFIFO_DATA_WIDTH 8  // bits per word

`define AFIFO_ADDR_WIDTH 4  // ram address bits

`define AFIFO_DEPTH (1 << `AFIFO_ADDR_WIDTH)

// ----------------------------------------------------------------------
// default flag thresholds in words
// ----------------------------------------------------------------------

`define AFIFO_AFULL_DEF 15

`define AFIFO_AEMPTY_DEF 1

`endif
